// File: hw/sd_pkg.sv
package sd_pkg;

    // ========================================================================
    // Frame and block sizes
    // ========================================================================
    localparam int CMD_PAYLOAD_BITS = 40;
    localparam int CRC7_BITS        = 7;
    localparam int FRAME_BITS       = 48;
    localparam int BLOCK_BITS       = 512;
    localparam int DAT_LANES        = 4;
    localparam int CRC16_BITS       = 16;
    localparam int WORD_BITS        = 16;
    localparam int BLOCK_CYCLES     = BLOCK_BITS / DAT_LANES;

    // Start bit, direction bit, index and argument
    typedef logic [CMD_PAYLOAD_BITS-1:0] cmd_payload_t;
    typedef logic [FRAME_BITS-1:0]       resp_frame_t;
    typedef logic [WORD_BITS-1:0]        dat_word_t;
    // One bit per DAT lane
    typedef logic [DAT_LANES-1:0]        dat_nibble_t;

    // ========================================================================
    // State machines
    // ========================================================================
    typedef enum logic [1:0] {
        cmd_idle,
        cmd_send,
        cmd_crc,
        cmd_stop
    } cmd_state_e;

    typedef enum logic [1:0] {
        resp_idle,
        resp_wait_start,
        resp_receive,
        resp_finish
    } resp_state_e;

    typedef enum logic [2:0] {
        dat_idle,
        dat_wait_start,
        dat_data,
        dat_crc,
        dat_end_bits
    } dat_state_e;

    typedef struct packed {
        cmd_payload_t payload;
        logic         want_resp;
        logic         want_dat;
    } cmd_req_t;

    // Strobes the lanes and the packer act on
    typedef struct packed {
        logic crc_clear;
        logic data_en;
        logic crc_check;
        logic end_check;
    } dat_phase_t;

    typedef struct packed {
        logic sample;
        logic err;
    } lane_status_t;

endpackage

// File: hw/sd_crc7.sv
module sd_crc7 (
    input  logic clk_fast,
    input  logic init_resetPulse,
    input  logic clear,
    input  logic advance,
    input  logic shift_out,
    input  logic din,
    output logic crc_msb
);

    logic [sd_pkg::CRC7_BITS-1:0] crc;
    logic                         feedback;

    // Polynomial x^7 + x^3 + 1
    assign feedback = din ^ crc[sd_pkg::CRC7_BITS-1];

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse || clear) begin
            crc <= '0;
        end else if (advance) begin
            crc <= {crc[sd_pkg::CRC7_BITS-2:0], 1'b0} ^ (feedback ? 7'h09 : 7'h00);
        end else if (shift_out) begin
            crc <= {crc[sd_pkg::CRC7_BITS-2:0], 1'b0};
        end
    end

    assign crc_msb = crc[sd_pkg::CRC7_BITS-1];

endmodule

// File: hw/sd_cmd_tx.sv
module sd_cmd_tx (
    input  logic             clk_fast,
    input  logic             init_resetPulse,
    input  logic             cmd_start,
    input  sd_pkg::cmd_req_t cmd_req,
    output logic             sd_cmd_out,
    output logic             sd_cmd_oe,
    output logic             cmd_done,
    output logic             expect_resp,
    output logic             expect_dat
);

    sd_pkg::cmd_state_e   state;
    sd_pkg::cmd_payload_t shift_q;
    logic [5:0]           bit_cnt;
    logic                 want_resp_q;
    logic                 want_dat_q;
    logic                 start_ok;
    logic                 crc_msb;

    // A trigger while busy is dropped
    assign start_ok = cmd_start && (state == sd_pkg::cmd_idle);

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state       <= sd_pkg::cmd_idle;
            bit_cnt     <= '0;
            want_resp_q <= 1'b0;
            want_dat_q  <= 1'b0;
            cmd_done    <= 1'b0;
            expect_resp <= 1'b0;
            expect_dat  <= 1'b0;
        end else begin
            cmd_done    <= (state == sd_pkg::cmd_stop);
            expect_resp <= (state == sd_pkg::cmd_stop) && want_resp_q;
            expect_dat  <= (state == sd_pkg::cmd_stop) && want_dat_q;
            bit_cnt     <= bit_cnt - 6'd1;
            case (state)
                sd_pkg::cmd_idle: begin
                    if (start_ok) begin
                        want_resp_q <= cmd_req.want_resp;
                        want_dat_q  <= cmd_req.want_dat;
                        bit_cnt     <= 6'(sd_pkg::CMD_PAYLOAD_BITS - 1);
                        state       <= sd_pkg::cmd_send;
                    end
                end
                sd_pkg::cmd_send: begin
                    if (bit_cnt == '0) begin
                        bit_cnt <= 6'(sd_pkg::CRC7_BITS - 1);
                        state   <= sd_pkg::cmd_crc;
                    end
                end
                sd_pkg::cmd_crc: begin
                    if (bit_cnt == '0) begin
                        state <= sd_pkg::cmd_stop;
                    end
                end
                default: begin
                    state <= sd_pkg::cmd_idle;
                end
            endcase
        end
    end

    // Payload goes out MSB first
    always_ff @(posedge clk_fast) begin
        if (start_ok) begin
            shift_q <= cmd_req.payload;
        end else if (state == sd_pkg::cmd_send) begin
            shift_q <= {shift_q[sd_pkg::CMD_PAYLOAD_BITS-2:0], 1'b0};
        end
    end

    sd_crc7 crc_i (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .clear           (start_ok),
        .advance         (state == sd_pkg::cmd_send),
        .shift_out       (state == sd_pkg::cmd_crc),
        .din             (shift_q[sd_pkg::CMD_PAYLOAD_BITS-1]),
        .crc_msb         (crc_msb)
    );

    always_comb begin
        case (state)
            sd_pkg::cmd_send: sd_cmd_out = shift_q[sd_pkg::CMD_PAYLOAD_BITS-1];
            sd_pkg::cmd_crc:  sd_cmd_out = crc_msb;
            default:          sd_cmd_out = 1'b1;
        endcase
    end

    assign sd_cmd_oe = (state != sd_pkg::cmd_idle);

    a_no_busy_start: assert property (
        @(posedge clk_fast) disable iff (init_resetPulse)
        cmd_start |-> state == sd_pkg::cmd_idle
    );

endmodule

// File: hw/sd_resp_rx.sv
module sd_resp_rx (
    input  logic                clk_fast,
    input  logic                init_resetPulse,
    input  logic                expect_resp,
    input  logic                sd_cmd_in,
    output logic                resp_done,
    output sd_pkg::resp_frame_t resp_data,
    output logic                resp_crc_err
);

    sd_pkg::resp_state_e state;
    logic [5:0]          bit_cnt;
    logic                crc_msb;
    logic                start_seen;
    logic                in_payload;
    logic                in_crc;

    assign start_seen = (state == sd_pkg::resp_wait_start) && !sd_cmd_in;
    // Bit index counts down from 47 at the start bit
    assign in_payload = (state == sd_pkg::resp_receive) && (bit_cnt > 6'(sd_pkg::CRC7_BITS));
    assign in_crc     = (state == sd_pkg::resp_receive) && !in_payload && (bit_cnt != '0);

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state        <= sd_pkg::resp_idle;
            bit_cnt      <= '0;
            resp_done    <= 1'b0;
            resp_crc_err <= 1'b0;
        end else begin
            resp_done <= 1'b0;
            case (state)
                sd_pkg::resp_wait_start: begin
                    if (start_seen) begin
                        bit_cnt <= 6'(sd_pkg::FRAME_BITS - 2);
                        state   <= sd_pkg::resp_receive;
                    end
                end
                sd_pkg::resp_receive: begin
                    bit_cnt <= bit_cnt - 6'd1;
                    if (in_crc && (sd_cmd_in != crc_msb)) begin
                        resp_crc_err <= 1'b1;
                    end
                    if (bit_cnt == '0) begin
                        // End bit
                        if (!sd_cmd_in) begin
                            resp_crc_err <= 1'b1;
                        end
                        resp_done <= 1'b1;
                        state     <= sd_pkg::resp_finish;
                    end
                end
                default: begin
                    state <= sd_pkg::resp_idle;
                end
            endcase
            if (expect_resp) begin
                resp_crc_err <= 1'b0;
                state        <= sd_pkg::resp_wait_start;
            end
        end
    end

    always_ff @(posedge clk_fast) begin
        if (start_seen || (state == sd_pkg::resp_receive)) begin
            resp_data <= {resp_data[sd_pkg::FRAME_BITS-2:0], sd_cmd_in};
        end
    end

    sd_crc7 crc_i (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .clear           (expect_resp),
        .advance         (start_seen || in_payload),
        .shift_out       (in_crc),
        .din             (sd_cmd_in),
        .crc_msb         (crc_msb)
    );

    // Done comes one full frame after the start bit was seen
    a_done_after_frame: assert property (
        @(posedge clk_fast) disable iff (init_resetPulse)
        resp_done |-> $past(state, sd_pkg::FRAME_BITS) == sd_pkg::resp_wait_start
    );

endmodule

// File: hw/sd_dat_rx_ctrl.sv
module sd_dat_rx_ctrl (
    input  logic               clk_fast,
    input  logic               init_resetPulse,
    input  logic               expect_dat,
    input  logic               dat0_in,
    output sd_pkg::dat_phase_t phase,
    output logic               dat_done
);

    sd_pkg::dat_state_e state;
    logic [6:0]         cyc_cnt;
    sd_pkg::dat_phase_t phase_next;

    // Lanes register their bit, so the strobes go out one cycle late to match
    always_comb begin
        phase_next.crc_clear = (state == sd_pkg::dat_wait_start) && !dat0_in;
        phase_next.data_en   = (state == sd_pkg::dat_data);
        phase_next.crc_check = (state == sd_pkg::dat_crc);
        phase_next.end_check = (state == sd_pkg::dat_end_bits);
    end

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state    <= sd_pkg::dat_idle;
            cyc_cnt  <= '0;
            phase    <= '0;
            dat_done <= 1'b0;
        end else begin
            phase    <= phase_next;
            dat_done <= phase_next.end_check;
            cyc_cnt  <= cyc_cnt - 7'd1;
            case (state)
                sd_pkg::dat_wait_start: begin
                    if (!dat0_in) begin
                        cyc_cnt <= 7'(sd_pkg::BLOCK_CYCLES - 1);
                        state   <= sd_pkg::dat_data;
                    end
                end
                sd_pkg::dat_data: begin
                    if (cyc_cnt == '0) begin
                        cyc_cnt <= 7'(sd_pkg::CRC16_BITS - 1);
                        state   <= sd_pkg::dat_crc;
                    end
                end
                sd_pkg::dat_crc: begin
                    if (cyc_cnt == '0) begin
                        state <= sd_pkg::dat_end_bits;
                    end
                end
                default: begin
                    state <= sd_pkg::dat_idle;
                end
            endcase
            if (expect_dat) begin
                state <= sd_pkg::dat_wait_start;
            end
        end
    end

    // Start bit, data cycles and CRC cycles come before the end-bit strobe
    a_block_length: assert property (
        @(posedge clk_fast) disable iff (init_resetPulse)
        phase.end_check |->
            $past(phase.crc_clear, sd_pkg::BLOCK_CYCLES + sd_pkg::CRC16_BITS + 1)
    );

endmodule

// File: hw/sd_dat_lane.sv
module sd_dat_lane (
    input  logic                 clk_fast,
    input  logic                 init_resetPulse,
    input  sd_pkg::dat_phase_t   phase,
    input  logic                 dat_in,
    output sd_pkg::lane_status_t status
);

    logic                          dat_q;
    logic                          err;
    logic [sd_pkg::CRC16_BITS-1:0] crc;
    logic                          feedback;

    always_ff @(posedge clk_fast) begin
        dat_q <= dat_in;
    end

    // Polynomial x^16 + x^12 + x^5 + 1
    assign feedback = dat_q ^ crc[sd_pkg::CRC16_BITS-1];

    always_ff @(posedge clk_fast) begin
        if (phase.crc_clear) begin
            crc <= '0;
        end else if (phase.data_en) begin
            crc <= {crc[sd_pkg::CRC16_BITS-2:0], 1'b0} ^ (feedback ? 16'h1021 : 16'h0000);
        end else if (phase.crc_check) begin
            crc <= {crc[sd_pkg::CRC16_BITS-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse || phase.crc_clear) begin
            err <= 1'b0;
        end else if (phase.crc_check && (dat_q != crc[sd_pkg::CRC16_BITS-1])) begin
            err <= 1'b1;
        end else if (phase.end_check && !dat_q) begin
            err <= 1'b1;
        end
    end

    assign status.sample = dat_q;
    assign status.err    = err;

endmodule

// File: hw/sd_dat_packer.sv
module sd_dat_packer (
    input  logic                                          clk_fast,
    input  logic                                          init_resetPulse,
    input  sd_pkg::dat_phase_t                            phase,
    input  sd_pkg::lane_status_t [sd_pkg::DAT_LANES-1:0] lanes,
    input  logic                                          dat_done_in,
    output logic                                          dat_word_valid,
    output sd_pkg::dat_word_t                             dat_word,
    output logic                                          dat_done,
    output logic                                          dat_crc_err
);

    sd_pkg::dat_nibble_t nibble;
    logic                any_err;
    logic [1:0]          nib_cnt;
    logic [5:0]          word_cnt;

    // Lane i lands on bit i of each nibble
    always_comb begin
        any_err = 1'b0;
        for (int i = 0; i < sd_pkg::DAT_LANES; i++) begin
            nibble[i] = lanes[i].sample;
            any_err   = any_err | lanes[i].err;
        end
    end

    // First nibble ends up in bits 15 to 12
    always_ff @(posedge clk_fast) begin
        if (phase.data_en) begin
            dat_word <= {dat_word[sd_pkg::WORD_BITS-sd_pkg::DAT_LANES-1:0], nibble};
        end
    end

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            nib_cnt        <= '0;
            word_cnt       <= '0;
            dat_word_valid <= 1'b0;
            dat_done       <= 1'b0;
        end else begin
            dat_word_valid <= phase.data_en && (nib_cnt == 2'd3);
            dat_done       <= dat_done_in;
            if (phase.crc_clear) begin
                nib_cnt  <= '0;
                word_cnt <= '0;
            end else if (phase.data_en) begin
                nib_cnt <= nib_cnt + 2'd1;
                if (nib_cnt == 2'd3) begin
                    word_cnt <= word_cnt + 6'd1;
                end
            end
        end
    end

    // Lane errors are final once the end-bit check has been taken
    assign dat_crc_err = any_err;

    a_full_block: assert property (
        @(posedge clk_fast) disable iff (init_resetPulse)
        dat_done_in |-> word_cnt == 6'(sd_pkg::BLOCK_BITS / sd_pkg::WORD_BITS)
    );

endmodule

// File: hw/sd_host_top.sv
module sd_host_top (
    input  logic                clk_fast,
    input  logic                init_resetPulse,
    input  logic                cmd_start,
    input  sd_pkg::cmd_req_t    cmd_req,
    output logic                cmd_done,
    output logic                resp_done,
    output sd_pkg::resp_frame_t resp_data,
    output logic                resp_crc_err,
    output logic                dat_word_valid,
    output sd_pkg::dat_word_t   dat_word,
    output logic                dat_done,
    output logic                dat_crc_err,
    input  logic                sd_cmd_in,
    output logic                sd_cmd_out,
    output logic                sd_cmd_oe,
    input  sd_pkg::dat_nibble_t sd_dat_in
);

    logic                                          expect_resp;
    logic                                          expect_dat;
    logic                                          ctrl_done;
    sd_pkg::dat_phase_t                            phase;
    sd_pkg::lane_status_t [sd_pkg::DAT_LANES-1:0] lane_status;

    // ========================================================================
    // Command and response
    // ========================================================================
    sd_cmd_tx cmd_tx_i (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .cmd_start       (cmd_start),
        .cmd_req         (cmd_req),
        .sd_cmd_out      (sd_cmd_out),
        .sd_cmd_oe       (sd_cmd_oe),
        .cmd_done        (cmd_done),
        .expect_resp     (expect_resp),
        .expect_dat      (expect_dat)
    );

    sd_resp_rx resp_rx_i (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .expect_resp     (expect_resp),
        .sd_cmd_in       (sd_cmd_in),
        .resp_done       (resp_done),
        .resp_data       (resp_data),
        .resp_crc_err    (resp_crc_err)
    );

    // ========================================================================
    // Data block receive
    // ========================================================================
    sd_dat_rx_ctrl dat_ctrl_i (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .expect_dat      (expect_dat),
        .dat0_in         (sd_dat_in[0]),
        .phase           (phase),
        .dat_done        (ctrl_done)
    );

    for (genvar i = 0; i < sd_pkg::DAT_LANES; i++) begin : g_lane
        sd_dat_lane lane_i (
            .clk_fast        (clk_fast),
            .init_resetPulse (init_resetPulse),
            .phase           (phase),
            .dat_in          (sd_dat_in[i]),
            .status          (lane_status[i])
        );
    end

    sd_dat_packer packer_i (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .phase           (phase),
        .lanes           (lane_status),
        .dat_done_in     (ctrl_done),
        .dat_word_valid  (dat_word_valid),
        .dat_word        (dat_word),
        .dat_done        (dat_done),
        .dat_crc_err     (dat_crc_err)
    );

endmodule

// File: sim/sd_host_tb.sv
module sd_host_tb;

    logic                clk_fast = 1'b0;
    logic                init_resetPulse;
    logic                cmd_start;
    sd_pkg::cmd_req_t    cmd_req;
    logic                cmd_done;
    logic                resp_done;
    sd_pkg::resp_frame_t resp_data;
    logic                resp_crc_err;
    logic                dat_word_valid;
    sd_pkg::dat_word_t   dat_word;
    logic                dat_done;
    logic                dat_crc_err;
    logic                sd_cmd_in;
    logic                sd_cmd_out;
    logic                sd_cmd_oe;
    sd_pkg::dat_nibble_t sd_dat_in;

    // Room for 16 tests of 7 fields each
    logic [39:0]  stim_mem [0:111];
    int           num_tests;
    int           cycle_cnt = 0;
    int           cycle_limit = 0;
    int           resp_cnt = 0;
    int           dat_cnt = 0;
    logic [15:0]  got_words [$];
    logic [15:0]  exp_words [32];
    logic [127:0] lane_bits [4];
    logic [15:0]  lane_crc [4];

    always #10 clk_fast = ~clk_fast;

    sd_host_top dut_i (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .cmd_start       (cmd_start),
        .cmd_req         (cmd_req),
        .cmd_done        (cmd_done),
        .resp_done       (resp_done),
        .resp_data       (resp_data),
        .resp_crc_err    (resp_crc_err),
        .dat_word_valid  (dat_word_valid),
        .dat_word        (dat_word),
        .dat_done        (dat_done),
        .dat_crc_err     (dat_crc_err),
        .sd_cmd_in       (sd_cmd_in),
        .sd_cmd_out      (sd_cmd_out),
        .sd_cmd_oe       (sd_cmd_oe),
        .sd_dat_in       (sd_dat_in)
    );

    // ========================================================================
    // Timeout and output monitor
    // ========================================================================
    always @(posedge clk_fast) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    // Done pulses and words are counted in the middle of the cycle
    always @(negedge clk_fast) begin
        if (!init_resetPulse) begin
            if (resp_done) begin
                resp_cnt = resp_cnt + 1;
            end
            if (dat_done) begin
                dat_cnt = dat_cnt + 1;
            end
            if (dat_word_valid) begin
                got_words.push_back(dat_word);
            end
        end
    end

    task automatic check_value(
        input string       name,
        input logic [63:0] got,
        input logic [63:0] exp
    );
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Errors found");
            $fatal(1, "run stopped at the first mismatch");
        end
    endtask

    task automatic next_drive_slot();
        @(posedge clk_fast);
        #2;
    endtask

    // CRC7 with polynomial x^7 + x^3 + 1 taken MSB first from a zero start value
    function automatic logic [6:0] calc_crc7(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb  = bits[i] ^ crc[6];
            crc = {crc[5:0], 1'b0} ^ {3'b000, fb, 2'b00, fb};
        end
        return crc;
    endfunction

    // CRC16 with polynomial x^16 + x^12 + x^5 + 1 over one lane with the first bit at the top
    function automatic logic [15:0] calc_crc16(input logic [127:0] bits);
        logic [15:0] crc;
        logic        fb;
        crc = '0;
        for (int i = 127; i >= 0; i--) begin
            fb  = bits[i] ^ crc[15];
            crc = {crc[14:0], 1'b0} ^ {3'b000, fb, 6'b000000, fb, 4'b0000, fb};
        end
        return crc;
    endfunction

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk_fast);
            check_value("sd_cmd_oe", 64'(sd_cmd_oe), 64'd0);
            check_value("cmd_done", 64'(cmd_done), 64'd0);
            check_value("resp_done", 64'(resp_done), 64'd0);
            check_value("dat_done", 64'(dat_done), 64'd0);
            check_value("dat_word_valid", 64'(dat_word_valid), 64'd0);
        end
    endtask

    // ========================================================================
    // Command frame, response and data block
    // ========================================================================
    task automatic send_command(input sd_pkg::cmd_req_t req);
        logic [47:0] frame;
        frame = {req.payload, calc_crc7(req.payload), 1'b1};
        next_drive_slot();
        cmd_start = 1'b1;
        cmd_req   = req;
        next_drive_slot();
        cmd_start = 1'b0;
        for (int k = 0; k < 48; k++) begin
            @(negedge clk_fast);
            check_value("sd_cmd_oe", 64'(sd_cmd_oe), 64'd1);
            check_value("sd_cmd_out", 64'(sd_cmd_out), 64'(frame[47 - k]));
            check_value("cmd_done", 64'(cmd_done), 64'd0);
        end
        // One cycle after the end bit
        @(negedge clk_fast);
        check_value("cmd_done", 64'(cmd_done), 64'd1);
        check_value("sd_cmd_oe", 64'(sd_cmd_oe), 64'd0);
    endtask

    // The frame is driven even when the host does not expect it
    task automatic card_response(
        input logic [39:0] payload,
        input int          gap,
        input int          fault,
        input logic        armed
    );
        logic [47:0] frame;
        frame = {payload, calc_crc7(payload), 1'b1};
        if (fault == 1) begin
            frame[1] = ~frame[1];
        end else if (fault == 2) begin
            frame[0] = 1'b0;
        end
        repeat (gap) @(posedge clk_fast);
        #2;
        for (int k = 0; k < 48; k++) begin
            sd_cmd_in = frame[47 - k];
            next_drive_slot();
        end
        sd_cmd_in = 1'b1;
        if (armed) begin
            @(negedge clk_fast);
            while (!resp_done) begin
                @(negedge clk_fast);
            end
            check_value("resp_data", 64'(resp_data), 64'(frame));
            check_value("resp_crc_err", 64'(resp_crc_err), 64'(fault != 0));
        end
    endtask

    task automatic card_read_block(input int fault_lane, input int word_base, input logic armed);
        sd_pkg::dat_nibble_t nib;
        for (int w = 0; w < 32; w++) begin
            exp_words[w] = 16'($urandom);
        end
        // Nibble j of a word sits at bits 15-4j down to 12-4j with lane i on bit i
        for (int c = 0; c < 128; c++) begin
            for (int i = 0; i < 4; i++) begin
                lane_bits[i][127 - c] = exp_words[c / 4][12 - 4 * (c % 4) + i];
            end
        end
        for (int i = 0; i < 4; i++) begin
            lane_crc[i] = calc_crc16(lane_bits[i]);
        end
        if (fault_lane != 0) begin
            lane_crc[fault_lane - 1] = lane_crc[fault_lane - 1] ^ 16'h0100;
        end
        next_drive_slot();
        sd_dat_in = 4'h0;
        for (int c = 0; c < 128; c++) begin
            next_drive_slot();
            for (int i = 0; i < 4; i++) begin
                nib[i] = lane_bits[i][127 - c];
            end
            sd_dat_in = nib;
        end
        for (int k = 0; k < 16; k++) begin
            next_drive_slot();
            for (int i = 0; i < 4; i++) begin
                nib[i] = lane_crc[i][15 - k];
            end
            sd_dat_in = nib;
        end
        next_drive_slot();
        sd_dat_in = 4'hF;
        if (armed) begin
            @(negedge clk_fast);
            while (!dat_done) begin
                @(negedge clk_fast);
            end
            check_value("dat_crc_err", 64'(dat_crc_err), 64'(fault_lane != 0));
            next_drive_slot();
            check_value("dat_word_valid count", 64'(got_words.size() - word_base),
                        64'd32);
            for (int w = 0; w < 32; w++) begin
                check_value("dat_word", 64'(got_words[word_base + w]), 64'(exp_words[w]));
            end
        end
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        int               base;
        int               gap;
        int               resp_base;
        int               dat_base;
        int               word_base;
        sd_pkg::cmd_req_t req;
        init_resetPulse = 1'b1;
        cmd_start       = 1'b0;
        cmd_req         = '0;
        sd_cmd_in       = 1'b1;
        sd_dat_in       = 4'hF;
        void'($urandom(60683));
        for (int a = 0; a < 112; a++) begin
            stim_mem[a] = '0;
        end
        $readmemh("sim/sd_stim.txt", stim_mem);
        // A valid command always has the direction bit set
        num_tests = 0;
        while (num_tests < 16 && stim_mem[num_tests * 7] != '0) begin
            num_tests++;
        end
        if (num_tests == 0) begin
            $display("No tests were found in sim/sd_stim.txt");
            $display("Errors found");
            $fatal(1, "empty stimulus file");
        end
        cycle_limit = num_tests * 1500;
        check_value("crc7 of CMD0", 64'(calc_crc7(40'h4000000000)), 64'h4a);

        repeat (4) @(posedge clk_fast);
        #2;
        init_resetPulse = 1'b0;
        check_quiet(10);

        for (int t = 0; t < num_tests; t++) begin
            base          = t * 7;
            req.payload   = stim_mem[base];
            req.want_resp = stim_mem[base + 1][0];
            req.want_dat  = stim_mem[base + 2][0];
            gap           = int'(stim_mem[base + 3]);
            next_drive_slot();
            resp_base = resp_cnt;
            dat_base  = dat_cnt;
            word_base = got_words.size();
            send_command(req);
            // The card answers every command, so a receiver armed by mistake shows up
            card_response(stim_mem[base + 4], (gap < 1) ? 1 : gap, int'(stim_mem[base + 5]),
                          req.want_resp);
            card_read_block(int'(stim_mem[base + 6]), word_base, req.want_dat);
            repeat (20) next_drive_slot();
            check_value("resp_done count", 64'(resp_cnt - resp_base), 64'(req.want_resp));
            check_value("dat_done count", 64'(dat_cnt - dat_base), 64'(req.want_dat));
        end

        // Reset in the middle of a command frame
        req.payload   = 40'h5100000000;
        req.want_resp = 1'b1;
        req.want_dat  = 1'b1;
        next_drive_slot();
        cmd_start = 1'b1;
        cmd_req   = req;
        next_drive_slot();
        cmd_start = 1'b0;
        repeat (10) next_drive_slot();
        init_resetPulse = 1'b1;
        repeat (4) next_drive_slot();
        init_resetPulse = 1'b0;
        check_quiet(60);

        $display("No errors");
        $finish;
    end

endmodule

// File: sim/sd_stim.txt
// cmd_payload want_resp want_dat gap resp_payload resp_fault dat_fault_lane
// resp_fault 0 none 1 bad CRC 2 bad end bit / dat_fault_lane 0 none or lane 1 to 4
4000000000 0 0 00 0000000000 0 0
48000001AA 1 0 03 08000001AA 0 0
7700000000 1 0 05 3700000120 1 0
4D00010000 1 0 02 0D00000900 2 0
5100000000 1 1 04 1100000900 0 0
5100000200 1 1 01 1100000900 0 1
5100000400 0 1 00 0000000000 0 2
5100000600 1 1 0A 1100000900 0 3
5100000800 1 1 02 1100000900 0 4
4700010000 1 0 07 0700000700 0 0

// File: sources.f
hw/sd_pkg.sv
hw/sd_crc7.sv
hw/sd_cmd_tx.sv
hw/sd_resp_rx.sv
hw/sd_dat_rx_ctrl.sv
hw/sd_dat_lane.sv
hw/sd_dat_packer.sv
hw/sd_host_top.sv
sim/sd_host_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Verilator build and run of the SD host testbench

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    --top-module sd_host_tb -Mdir "$build_dir" -o sd_host_sim -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/sd_host_sim" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "Errors found" "$log_file"; then
    echo "Simulation failed"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "Simulation passed"
exit 0
